//--- design/periph_pkg.sv
// Peripheral subsystem shared definitions
// Bus widths, peripheral selectors, register map and response codes

package periph_pkg;

  localparam int DATA_W = 32;

  // Address word as seen by the demux and by each peripheral
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [19:0] unused;
      logic [3:0]  sel;
      logic [5:0]  reg_idx;
      logic [1:0]  byte_off;
    } fields;
  } periph_addr_u;

  // Peripheral select field values, others unmapped
  localparam logic [3:0] SEL_GPIO  = 4'd0;
  localparam logic [3:0] SEL_TIMER = 4'd1;
  localparam logic [3:0] SEL_IRQ   = 4'd2;

  // GPIO registers
  localparam logic [5:0] GPIO_DATA_IN     = 6'd0;
  localparam logic [5:0] GPIO_DATA_OUT    = 6'd1;
  localparam logic [5:0] GPIO_OUT_EN      = 6'd2;
  localparam logic [5:0] GPIO_RISE_EN     = 6'd3;
  localparam logic [5:0] GPIO_RISE_STATUS = 6'd4;

  // Timer registers
  localparam logic [5:0] TMR_COUNT   = 6'd0;
  localparam logic [5:0] TMR_COMPARE = 6'd1;
  localparam logic [5:0] TMR_CTRL    = 6'd2;
  localparam logic [5:0] TMR_STATUS  = 6'd3;

  // Interrupt controller registers
  localparam logic [5:0] IRQ_PENDING = 6'd0;
  localparam logic [5:0] IRQ_ENABLE  = 6'd1;
  localparam logic [5:0] IRQ_CLAIM   = 6'd2;

  // Internal source positions, external lines start at 2
  localparam int IRQ_SRC_GPIO  = 0;
  localparam int IRQ_SRC_TIMER = 1;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Merge of write data into an old value under a bit mask
  function automatic logic [DATA_W-1:0] masked_write(input logic [DATA_W-1:0] old_val,
                                                     input logic [DATA_W-1:0] wdata,
                                                     input logic [DATA_W-1:0] wmask);
    return (old_val & ~wmask) | (wdata & wmask);
  endfunction

endpackage

//--- design/periph_axil_bridge.sv
// AXI4-Lite slave bridge
// Holds one transaction and replays it as a single-cycle register access
`timescale 1ns/1ps

module periph_axil_bridge (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [31:0] s_awaddr_i,
  input  logic        s_awvalid_i,
  output logic        s_awready_o,
  input  logic [31:0] s_wdata_i,
  input  logic [3:0]  s_wstrb_i,
  input  logic        s_wvalid_i,
  output logic        s_wready_o,
  output logic [1:0]  s_bresp_o,
  output logic        s_bvalid_o,
  input  logic        s_bready_i,
  input  logic [31:0] s_araddr_i,
  input  logic        s_arvalid_i,
  output logic        s_arready_o,
  output logic [31:0] s_rdata_o,
  output logic [1:0]  s_rresp_o,
  output logic        s_rvalid_o,
  input  logic        s_rready_i,
  output logic        reg_valid_o,
  output logic        reg_write_o,
  output logic [31:0] reg_addr_o,
  output logic [31:0] reg_wdata_o,
  output logic [31:0] reg_wmask_o,
  input  logic [31:0] reg_rdata_i,
  input  logic        reg_error_i
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_ACCESS  = 2'd1;
  localparam logic [1:0] ST_RESPOND = 2'd2;

  logic [1:0]  state_q;
  logic        is_write_q;
  logic        wr_accept;
  logic        rd_accept;
  logic        resp_done;
  logic [31:0] rdata_q;
  logic [1:0]  resp_q;

  // Write wins when both directions arrive together
  assign wr_accept = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
  assign rd_accept = (state_q == ST_IDLE) && s_arvalid_i && !s_awvalid_i && !s_wvalid_i;

  assign s_awready_o = wr_accept;
  assign s_wready_o  = wr_accept;
  assign s_arready_o = rd_accept;

  assign s_bvalid_o = (state_q == ST_RESPOND) && is_write_q;
  assign s_rvalid_o = (state_q == ST_RESPOND) && !is_write_q;
  assign s_bresp_o  = resp_q;
  assign s_rresp_o  = resp_q;
  assign s_rdata_o  = rdata_q;
  assign resp_done  = (s_bvalid_o && s_bready_i) || (s_rvalid_o && s_rready_i);

  assign reg_valid_o = (state_q == ST_ACCESS);
  assign reg_write_o = is_write_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      is_write_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_accept || rd_accept) begin
            state_q    <= ST_ACCESS;
            is_write_q <= wr_accept;
          end
        end
        ST_ACCESS: state_q <= ST_RESPOND;
        ST_RESPOND: begin
          if (resp_done) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload and registered response
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      reg_addr_o  <= s_awaddr_i;
      reg_wdata_o <= s_wdata_i;
      for (int i = 0; i < 4; i++) begin
        reg_wmask_o[i*8 +: 8] <= {8{s_wstrb_i[i]}};
      end
    end else if (rd_accept) begin
      reg_addr_o <= s_araddr_i;
    end
    if (state_q == ST_ACCESS) begin
      rdata_q <= reg_rdata_i;
      resp_q  <= reg_error_i ? periph_pkg::RESP_SLVERR : periph_pkg::RESP_OKAY;
    end
  end

endmodule

//--- design/periph_reg_demux.sv
// Register bus demux
// Routes an access by peripheral select and merges the responses
`timescale 1ns/1ps

module periph_reg_demux (
  input  logic        reg_valid_i,
  input  logic [31:0] reg_addr_i,
  output logic        gpio_valid_o,
  output logic        timer_valid_o,
  output logic        irq_valid_o,
  input  logic [31:0] gpio_rdata_i,
  input  logic        gpio_error_i,
  input  logic [31:0] timer_rdata_i,
  input  logic        timer_error_i,
  input  logic [31:0] irq_rdata_i,
  input  logic        irq_error_i,
  output logic [31:0] reg_rdata_o,
  output logic        reg_error_o
);

  periph_pkg::periph_addr_u addr;

  assign addr.raw = reg_addr_i;

  always_comb begin
    gpio_valid_o  = 1'b0;
    timer_valid_o = 1'b0;
    irq_valid_o   = 1'b0;
    // Unmapped select answers with an error and zero data
    reg_rdata_o   = '0;
    reg_error_o   = 1'b1;
    case (addr.fields.sel)
      periph_pkg::SEL_GPIO: begin
        gpio_valid_o = reg_valid_i;
        reg_rdata_o  = gpio_rdata_i;
        reg_error_o  = gpio_error_i;
      end
      periph_pkg::SEL_TIMER: begin
        timer_valid_o = reg_valid_i;
        reg_rdata_o   = timer_rdata_i;
        reg_error_o   = timer_error_i;
      end
      periph_pkg::SEL_IRQ: begin
        irq_valid_o = reg_valid_i;
        reg_rdata_o = irq_rdata_i;
        reg_error_o = irq_error_i;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- design/periph_gpio.sv
// GPIO block
// Output and enable registers, synchronized inputs, rising-edge interrupt status
`timescale 1ns/1ps

module periph_gpio #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  logic                  write_i,
  input  logic [31:0]           addr_i,
  input  logic [31:0]           wdata_i,
  input  logic [31:0]           wmask_i,
  output logic [31:0]           rdata_o,
  output logic                  error_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_en_o,
  output logic                  intr_o
);

  periph_pkg::periph_addr_u addr;
  logic [GPIO_WIDTH-1:0] sync1_q, sync2_q, prev_q;
  logic [GPIO_WIDTH-1:0] rise_en_q, status_q, rise;
  logic [31:0]           merged;
  logic                  wr_en;

  assign addr.raw = addr_i;
  assign wr_en    = valid_i && write_i && !error_o;
  assign merged   = periph_pkg::masked_write(rdata_o, wdata_i, wmask_i);
  assign rise     = sync2_q & ~prev_q & rise_en_q;
  assign intr_o   = |status_q;

  always_comb begin
    rdata_o = '0;
    error_o = 1'b0;
    case (addr.fields.reg_idx)
      periph_pkg::GPIO_DATA_IN:     rdata_o = 32'(sync2_q);
      periph_pkg::GPIO_DATA_OUT:    rdata_o = 32'(gpio_o);
      periph_pkg::GPIO_OUT_EN:      rdata_o = 32'(gpio_en_o);
      periph_pkg::GPIO_RISE_EN:     rdata_o = 32'(rise_en_q);
      periph_pkg::GPIO_RISE_STATUS: rdata_o = 32'(status_q);
      default:                      error_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      gpio_o    <= '0;
      gpio_en_o <= '0;
      rise_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && addr.fields.reg_idx == periph_pkg::GPIO_DATA_OUT) begin
        gpio_o <= merged[GPIO_WIDTH-1:0];
      end
      if (wr_en && addr.fields.reg_idx == periph_pkg::GPIO_OUT_EN) begin
        gpio_en_o <= merged[GPIO_WIDTH-1:0];
      end
      if (wr_en && addr.fields.reg_idx == periph_pkg::GPIO_RISE_EN) begin
        rise_en_q <= merged[GPIO_WIDTH-1:0];
      end
      // A new edge beats a clear in the same cycle
      if (wr_en && addr.fields.reg_idx == periph_pkg::GPIO_RISE_STATUS) begin
        status_q <= (status_q & ~(wdata_i[GPIO_WIDTH-1:0] & wmask_i[GPIO_WIDTH-1:0])) | rise;
      end else begin
        status_q <= status_q | rise;
      end
    end
  end

endmodule

//--- design/periph_timer.sv
// Compare timer
// 32-bit counter with compare match, optional auto-reload and expired flag
`timescale 1ns/1ps

module periph_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        valid_i,
  input  logic        write_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [31:0] wmask_i,
  output logic [31:0] rdata_o,
  output logic        error_o,
  output logic        intr_o
);

  periph_pkg::periph_addr_u addr;
  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic        enable_q;
  logic        reload_q;
  logic        expired_q;
  logic [31:0] merged;
  logic        wr_en;
  logic        hit;

  assign addr.raw = addr_i;
  assign wr_en    = valid_i && write_i && !error_o;
  assign merged   = periph_pkg::masked_write(rdata_o, wdata_i, wmask_i);
  assign hit      = enable_q && (count_q == compare_q);
  assign intr_o   = expired_q;

  always_comb begin
    rdata_o = '0;
    error_o = 1'b0;
    case (addr.fields.reg_idx)
      periph_pkg::TMR_COUNT:   rdata_o = count_q;
      periph_pkg::TMR_COMPARE: rdata_o = compare_q;
      periph_pkg::TMR_CTRL:    rdata_o = {30'd0, reload_q, enable_q};
      periph_pkg::TMR_STATUS:  rdata_o = {31'd0, expired_q};
      default:                 error_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      reload_q  <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      // Software write to COUNT overrides the increment
      if (wr_en && addr.fields.reg_idx == periph_pkg::TMR_COUNT) begin
        count_q <= merged;
      end else if (hit && reload_q) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && addr.fields.reg_idx == periph_pkg::TMR_COMPARE) compare_q <= merged;
      if (wr_en && addr.fields.reg_idx == periph_pkg::TMR_CTRL) begin
        enable_q <= merged[0];
        reload_q <= merged[1];
      end
      if (wr_en && addr.fields.reg_idx == periph_pkg::TMR_STATUS) begin
        expired_q <= (expired_q & ~(wdata_i[0] & wmask_i[0])) | hit;
      end else begin
        expired_q <= expired_q | hit;
      end
    end
  end

endmodule

//--- design/periph_irq_ctrl.sv
// Interrupt controller
// Latches source edges as pending, masks them and hands out ids through CLAIM
`timescale 1ns/1ps

module periph_irq_ctrl #(
  parameter int NUM_SRC = 6
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  logic               write_i,
  input  logic [31:0]        addr_i,
  input  logic [31:0]        wdata_i,
  input  logic [31:0]        wmask_i,
  output logic [31:0]        rdata_o,
  output logic               error_o,
  input  logic [NUM_SRC-1:0] irq_src_i,
  output logic               irq_o
);

  localparam int IDX_W = $clog2(NUM_SRC);

  periph_pkg::periph_addr_u addr;
  logic [NUM_SRC-1:0] src_q;
  logic [NUM_SRC-1:0] pending_q;
  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] active;
  logic [NUM_SRC-1:0] claim_clr;
  logic [IDX_W-1:0]   claim_idx;
  logic               claim_found;
  logic [31:0]        claim_id;
  logic [31:0]        merged;

  assign addr.raw = addr_i;
  assign active   = pending_q & enable_q;
  assign merged   = periph_pkg::masked_write(rdata_o, wdata_i, wmask_i);

  // Lowest enabled pending source wins the claim
  always_comb begin
    claim_found = 1'b0;
    claim_idx   = '0;
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_found = 1'b1;
        claim_idx   = IDX_W'(i);
      end
    end
  end

  assign claim_id = claim_found ? 32'(claim_idx) + 32'd1 : 32'd0;
  assign claim_clr = (valid_i && !write_i && claim_found &&
                      addr.fields.reg_idx == periph_pkg::IRQ_CLAIM) ?
                     (NUM_SRC'(1) << claim_idx) : '0;

  always_comb begin
    rdata_o = '0;
    error_o = 1'b0;
    case (addr.fields.reg_idx)
      periph_pkg::IRQ_PENDING: rdata_o = 32'(pending_q);
      periph_pkg::IRQ_ENABLE:  rdata_o = 32'(enable_q);
      periph_pkg::IRQ_CLAIM:   rdata_o = claim_id;
      default:                 error_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      irq_o     <= 1'b0;
    end else begin
      src_q     <= irq_src_i;
      pending_q <= (pending_q & ~claim_clr) | (irq_src_i & ~src_q);
      irq_o     <= |active;
      // PENDING and CLAIM take no writes
      if (valid_i && write_i && addr.fields.reg_idx == periph_pkg::IRQ_ENABLE) begin
        enable_q <= merged[NUM_SRC-1:0];
      end
    end
  end

endmodule

//--- design/peripheral_subsystem.sv
// Peripheral subsystem top
// AXI4-Lite bridge, register demux, GPIO, timer and interrupt controller
`timescale 1ns/1ps

module peripheral_subsystem #(
  parameter int GPIO_WIDTH  = 16,
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [31:0]            s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  logic [31:0]            s_wdata_i,
  input  logic [3:0]             s_wstrb_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  output logic [1:0]             s_bresp_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  input  logic [31:0]            s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  output logic [31:0]            s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i,
  input  logic [GPIO_WIDTH-1:0]  gpio_i,
  output logic [GPIO_WIDTH-1:0]  gpio_o,
  output logic [GPIO_WIDTH-1:0]  gpio_en_o,
  input  logic [NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                   irq_o
);

  localparam int NUM_SRC = 2 + NUM_EXT_IRQ;

  logic        reg_valid, reg_write, reg_error;
  logic [31:0] reg_addr, reg_wdata, reg_wmask, reg_rdata;
  logic        gpio_valid, timer_valid, irq_valid;
  logic [31:0] gpio_rdata, timer_rdata, irq_rdata;
  logic        gpio_error, timer_error, irq_error;
  logic        gpio_intr, timer_intr;
  logic [NUM_SRC-1:0] irq_src;

  assign irq_src[periph_pkg::IRQ_SRC_GPIO]  = gpio_intr;
  assign irq_src[periph_pkg::IRQ_SRC_TIMER] = timer_intr;
  assign irq_src[NUM_SRC-1:periph_pkg::IRQ_SRC_TIMER+1] = ext_irq_i;

  periph_axil_bridge u_bridge (
    .clk_i, .rst_n_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .reg_valid_o(reg_valid), .reg_write_o(reg_write), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_wmask_o(reg_wmask),
    .reg_rdata_i(reg_rdata), .reg_error_i(reg_error)
  );

  periph_reg_demux u_demux (
    .reg_valid_i(reg_valid), .reg_addr_i(reg_addr),
    .gpio_valid_o(gpio_valid), .timer_valid_o(timer_valid), .irq_valid_o(irq_valid),
    .gpio_rdata_i(gpio_rdata), .gpio_error_i(gpio_error),
    .timer_rdata_i(timer_rdata), .timer_error_i(timer_error),
    .irq_rdata_i(irq_rdata), .irq_error_i(irq_error),
    .reg_rdata_o(reg_rdata), .reg_error_o(reg_error)
  );

  periph_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
    .clk_i, .rst_n_i,
    .valid_i(gpio_valid), .write_i(reg_write), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .wmask_i(reg_wmask),
    .rdata_o(gpio_rdata), .error_o(gpio_error),
    .gpio_i, .gpio_o, .gpio_en_o, .intr_o(gpio_intr)
  );

  periph_timer u_timer (
    .clk_i, .rst_n_i,
    .valid_i(timer_valid), .write_i(reg_write), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .wmask_i(reg_wmask),
    .rdata_o(timer_rdata), .error_o(timer_error), .intr_o(timer_intr)
  );

  periph_irq_ctrl #(.NUM_SRC(NUM_SRC)) u_irq_ctrl (
    .clk_i, .rst_n_i,
    .valid_i(irq_valid), .write_i(reg_write), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .wmask_i(reg_wmask),
    .rdata_o(irq_rdata), .error_o(irq_error),
    .irq_src_i(irq_src), .irq_o
  );

endmodule

//--- dv/tb_tests.svh
// Directed tests for the peripheral subsystem
// Each task drives the DUT through one behavior and checks the results
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic test_gpio_outputs();
  logic [31:0] out_addr, en_addr, dout, oen, part, exp_out, rd;
  logic [1:0]  resp;
  out_addr = reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_DATA_OUT);
  en_addr  = reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT_EN);
  dout = $urandom;
  oen  = $urandom;
  part = $urandom;
  write_reg("gpio data_out write", out_addr, dout);
  write_reg("gpio out_en write", en_addr, oen);
  // Strobe on byte 1 only
  axil_write(out_addr, part, 4'b0010, resp);
  check_resp("gpio partial write", periph_pkg::RESP_OKAY, resp);
  exp_out = ((dout & ~32'h0000_ff00) | (part & 32'h0000_ff00)) & GPIO_MASK;
  check_data("gpio_o pins", exp_out, 32'(gpio_o));
  check_data("gpio_en_o pins", oen & GPIO_MASK, 32'(gpio_en_o));
  read_reg("gpio data_out read", out_addr, rd);
  check_data("gpio data_out read", exp_out, rd);
  read_reg("gpio out_en read", en_addr, rd);
  check_data("gpio out_en read", oen & GPIO_MASK, rd);
endtask

task automatic test_gpio_irq();
  logic [31:0] pattern, rise_en, rd;
  int          tries;
  pattern = ($urandom | 32'h1) & GPIO_MASK;
  rise_en = ($urandom | 32'h1) & GPIO_MASK;
  write_reg("gpio rise_en", reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_RISE_EN), rise_en);
  gpio_i = pattern[GPIO_WIDTH-1:0];
  tries = 0;
  do begin
    read_reg("gpio data_in", reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_DATA_IN), rd);
    tries++;
  end while (rd != pattern && tries < 10);
  check_data("gpio data_in", pattern, rd);
  read_reg("gpio status", reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_RISE_STATUS), rd);
  check_data("gpio rise_status", pattern & rise_en, rd);
  write_reg("irq enable gpio", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE),
            32'd1 << periph_pkg::IRQ_SRC_GPIO);
  wait_irq(1'b1, "gpio interrupt");
  read_reg("gpio claim", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM), rd);
  check_data("gpio claim", 32'(periph_pkg::IRQ_SRC_GPIO + 1), rd);
  write_reg("gpio status clear", reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_RISE_STATUS),
            32'hffff_ffff);
  read_reg("gpio status after clear",
           reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_RISE_STATUS), rd);
  check_data("gpio rise_status cleared", 32'h0, rd);
  read_reg("irq pending", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_PENDING), rd);
  check_data("irq pending gpio bit", 32'h0, rd & (32'd1 << periph_pkg::IRQ_SRC_GPIO));
  wait_irq(1'b0, "gpio interrupt release");
endtask

task automatic test_timer();
  logic [31:0] cmp, cnt_val, rd;
  int          tries;
  cmp = 32'd8 + ($urandom % 24);
  write_reg("irq enable timer", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE),
            32'd1 << periph_pkg::IRQ_SRC_TIMER);
  write_reg("timer compare", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_COMPARE), cmp);
  // Enable plus auto-reload
  write_reg("timer start", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_CTRL), 32'h3);
  tries = 0;
  do begin
    read_reg("timer status", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_STATUS), rd);
    tries++;
  end while (rd != 32'h1 && tries < 40);
  check_data("timer expired", 32'h1, rd);
  read_reg("timer claim", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM), rd);
  check_data("timer claim", 32'(periph_pkg::IRQ_SRC_TIMER + 1), rd);
  read_reg("timer count", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_COUNT), rd);
  if (rd > cmp) report_failure($sformatf("timer count %0d is above compare %0d", rd, cmp));
  write_reg("timer stop", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_CTRL), 32'h0);
  cnt_val = $urandom;
  write_reg("timer count write", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_COUNT), cnt_val);
  read_reg("timer count read", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_COUNT), rd);
  check_data("timer count read", cnt_val, rd);
  write_reg("timer status clear", reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_STATUS), 32'h1);
  read_reg("timer status after clear",
           reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TMR_STATUS), rd);
  check_data("timer status cleared", 32'h0, rd);
endtask

task automatic test_ext_irq();
  logic [31:0] claim_addr, rd;
  logic        quiet;
  int          a, b, lo, hi, base;
  claim_addr = reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM);
  base = periph_pkg::IRQ_SRC_TIMER + 1;
  a = $urandom % NUM_EXT_IRQ;
  b = (a + 1 + $urandom % (NUM_EXT_IRQ - 1)) % NUM_EXT_IRQ;
  lo = (a < b) ? a : b;
  hi = (a < b) ? b : a;
  write_reg("irq enable ext", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE),
            (32'd1 << (base + a)) | (32'd1 << (base + b)));
  ext_irq_i[a] = 1'b1;
  ext_irq_i[b] = 1'b1;
  wait_irq(1'b1, "external interrupt");
  // Claim ids are the source index plus one, lowest first
  read_reg("ext claim low", claim_addr, rd);
  check_data("ext claim low", 32'(base + lo + 1), rd);
  read_reg("ext claim high", claim_addr, rd);
  check_data("ext claim high", 32'(base + hi + 1), rd);
  read_reg("ext claim empty", claim_addr, rd);
  check_data("ext claim empty", 32'h0, rd);
  ext_irq_i = '0;
  wait_irq(1'b0, "external interrupt release");
  write_reg("irq enable none", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE), 32'h0);
  ext_irq_i[a] = 1'b1;
  quiet = 1'b1;
  repeat (8) begin
    @(negedge clk_i);
    if (irq_o) quiet = 1'b0;
  end
  if (!quiet) report_failure("irq_o rose for a source that is not enabled");
  @(posedge clk_i);
  #1;
  read_reg("masked pending", reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_PENDING), rd);
  check_data("masked pending", 32'd1 << (base + a), rd);
  ext_irq_i = '0;
endtask

task automatic test_errors();
  logic [31:0] out_addr, en_addr, out_before, en_before, rd;
  logic [3:0]  bad_sel;
  logic [5:0]  bad_idx;
  logic [1:0]  resp;
  out_addr = reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_DATA_OUT);
  en_addr  = reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT_EN);
  read_reg("gpio data_out before", out_addr, out_before);
  read_reg("gpio out_en before", en_addr, en_before);
  bad_sel = 4'(3 + $urandom % 13);
  bad_idx = 6'(5 + $urandom % 59);
  axil_write(reg_addr(bad_sel, periph_pkg::GPIO_DATA_OUT), ~out_before, 4'hf, resp);
  check_resp("unmapped sel write", periph_pkg::RESP_SLVERR, resp);
  axil_read(reg_addr(bad_sel, periph_pkg::GPIO_OUT_EN), rd, resp);
  check_resp("unmapped sel read", periph_pkg::RESP_SLVERR, resp);
  check_data("unmapped sel read", 32'h0, rd);
  axil_write(reg_addr(periph_pkg::SEL_GPIO, bad_idx), ~en_before, 4'hf, resp);
  check_resp("unknown gpio reg write", periph_pkg::RESP_SLVERR, resp);
  axil_read(reg_addr(periph_pkg::SEL_GPIO, bad_idx), rd, resp);
  check_resp("unknown gpio reg read", periph_pkg::RESP_SLVERR, resp);
  check_data("unknown gpio reg read", 32'h0, rd);
  read_reg("gpio data_out after", out_addr, rd);
  check_data("gpio data_out unchanged", out_before, rd);
  read_reg("gpio out_en after", en_addr, rd);
  check_data("gpio out_en unchanged", en_before, rd);
endtask

task automatic test_backpressure();
  logic [31:0] addr, wval, rd;
  logic [1:0]  wresp, rresp;
  time         t_w, t_r;
  addr = reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_DATA_OUT);
  wval = $urandom & GPIO_MASK;
  hold_cycles = 2 + ($urandom % 6);
  write_reg("stalled write", addr, wval);
  read_reg("stalled read", addr, rd);
  check_data("stalled read", wval, rd);
  hold_cycles = 0;
  // Write and read presented in the same cycle
  wval = $urandom & GPIO_MASK;
  fork
    begin
      axil_write(addr, wval, 4'hf, wresp);
      t_w = $time;
    end
    begin
      axil_read(addr, rd, rresp);
      t_r = $time;
    end
  join
  if (t_w >= t_r) report_failure("read finished before the write presented with it");
  check_resp("concurrent write", periph_pkg::RESP_OKAY, wresp);
  check_resp("concurrent read", periph_pkg::RESP_OKAY, rresp);
  check_data("concurrent read", wval, rd);
endtask

`endif

//--- dv/tb_peripheral_subsystem.sv
// Testbench for the peripheral subsystem
// Drives AXI4-Lite accesses and checks registers, pins and the interrupt output
`timescale 1ns/1ps

module tb_peripheral_subsystem;

  localparam int GPIO_WIDTH  = 16;
  localparam int NUM_EXT_IRQ = 4;
  localparam int NUM_TESTS   = 6;
  localparam logic [31:0] GPIO_MASK = 32'((64'd1 << GPIO_WIDTH) - 64'd1);

  logic                   clk_i, rst_n_i;
  logic [31:0]            s_awaddr_i, s_wdata_i, s_araddr_i, s_rdata_o;
  logic [3:0]             s_wstrb_i;
  logic                   s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
  logic [1:0]             s_bresp_o, s_rresp_o;
  logic                   s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o;
  logic                   s_rvalid_o, s_rready_i;
  logic [GPIO_WIDTH-1:0]  gpio_i, gpio_o, gpio_en_o;
  logic [NUM_EXT_IRQ-1:0] ext_irq_i;
  logic                   irq_o;

  int data_errs = 0;
  int resp_errs = 0;
  int other_errs = 0;
  // Cycles the master stalls bready or rready once a response is valid
  int hold_cycles = 0;

  peripheral_subsystem #(.GPIO_WIDTH(GPIO_WIDTH), .NUM_EXT_IRQ(NUM_EXT_IRQ)) UUT (.*);

  task automatic check_data(input string name, input logic [periph_pkg::DATA_W-1:0] expected,
                            input logic [periph_pkg::DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      data_errs++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected resp %02b, actual resp %02b", name, expected, actual);
      resp_errs++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    other_errs++;
  endtask

  function automatic logic [31:0] reg_addr(input logic [3:0] sel, input logic [5:0] idx);
    periph_pkg::periph_addr_u a;
    a.raw = '0;
    a.fields.sel = sel;
    a.fields.reg_idx = idx;
    return a.raw;
  endfunction

  // All bus tasks start and end 1 ns after a rising edge
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    @(negedge clk_i);
    while (!(s_awready_o && s_wready_o)) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    @(negedge clk_i);
    while (!s_bvalid_o) @(negedge clk_i);
    resp = s_bresp_o;
    repeat (hold_cycles) begin
      @(negedge clk_i);
      if (!s_bvalid_o) report_failure("bvalid dropped before bready");
      check_resp("bresp under back-pressure", resp, s_bresp_o);
    end
    @(posedge clk_i);
    #1;
    s_bready_i = 1'b1;
    @(posedge clk_i);
    #1;
    s_bready_i = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    @(negedge clk_i);
    while (!s_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    s_arvalid_i = 1'b0;
    @(negedge clk_i);
    while (!s_rvalid_o) @(negedge clk_i);
    data = s_rdata_o;
    resp = s_rresp_o;
    repeat (hold_cycles) begin
      @(negedge clk_i);
      if (!s_rvalid_o) report_failure("rvalid dropped before rready");
      check_data("rdata under back-pressure", data, s_rdata_o);
      check_resp("rresp under back-pressure", resp, s_rresp_o);
    end
    @(posedge clk_i);
    #1;
    s_rready_i = 1'b1;
    @(posedge clk_i);
    #1;
    s_rready_i = 1'b0;
  endtask

  task automatic write_reg(input string name, input logic [31:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, 4'hf, resp);
    check_resp(name, periph_pkg::RESP_OKAY, resp);
  endtask

  task automatic read_reg(input string name, input logic [31:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_resp(name, periph_pkg::RESP_OKAY, resp);
  endtask

  task automatic wait_irq(input logic level, input string name);
    int n;
    n = 0;
    while (irq_o !== level && n < 16) begin
      @(negedge clk_i);
      n++;
    end
    if (irq_o !== level) report_failure($sformatf("%s: irq_o never went to %0d", name, level));
    @(posedge clk_i);
    #1;
  endtask

  `include "tb_tests.svh"

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk_i);
    $display("Error: run timed out after %0d cycles", NUM_TESTS * 2000);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hb2d4));
    rst_n_i     = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    gpio_i      = '0;
    ext_irq_i   = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    if (s_awready_o || s_wready_o || s_arready_o || s_bvalid_o || s_rvalid_o || irq_o) begin
      report_failure("ready, valid or irq output high after reset");
    end
    test_gpio_outputs();
    test_gpio_irq();
    test_timer();
    test_ext_irq();
    test_errors();
    test_backpressure();
    $display("Errors: %0d total (data %0d, response %0d, other %0d)",
             data_errs + resp_errs + other_errs, data_errs, resp_errs, other_errs);
    if (data_errs + resp_errs + other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+dv
design/periph_pkg.sv
design/periph_axil_bridge.sv
design/periph_reg_demux.sv
design/periph_gpio.sv
design/periph_timer.sv
design/periph_irq_ctrl.sv
design/peripheral_subsystem.sv
dv/tb_peripheral_subsystem.sv

//--- run.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
  --top-module tb_peripheral_subsystem -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
